// File: scope_params.svh
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Scope capture sizing
////////////////////////////////////////////////////////////////////////////

// ADC word width
`define SCOPE_SAMPLE_W 12

// Clocks per sample strobe
// 4 keeps simulation short, hardware timebase runs at 500
`define SCOPE_DIV 4

// Words stored per trigger
`define SCOPE_DEPTH 32

// Capture memory address width, log2 of SCOPE_DEPTH
`define SCOPE_ADDR_W 5

// Hysteresis half-width in ADC counts
`define SCOPE_HYST 8

`endif

// File: trigger_pkg.sv
package trigger_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Level trigger types
    ////////////////////////////////////////////////////////////////////////////

    // Hysteresis FSM states
    typedef enum logic [1:0] {
        TRIG_IDLE       = 2'd0, // Not armed, nothing evaluated
        TRIG_WAIT_FAR   = 2'd1, // Waiting for signal beyond the band
        TRIG_WAIT_CROSS = 2'd2  // Waiting for the level crossing
    } trig_state_t;

    // Crossing direction
    typedef enum logic {
        SLOPE_RISE = 1'b0,
        SLOPE_FALL = 1'b1
    } slope_t;

endpackage

// File: capture_pkg.sv
package capture_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Capture control types
    ////////////////////////////////////////////////////////////////////////////

    // Capture status as seen by the host
    typedef enum logic [1:0] {
        CAP_IDLE  = 2'd0, // Nothing pending
        CAP_ARMED = 2'd1, // Waiting for trigger
        CAP_RUN   = 2'd2, // Writing the record
        CAP_DONE  = 2'd3  // Record complete, ready for readout
    } cap_status_t;

    // Host command opcodes
    typedef enum logic {
        CMD_ARM   = 1'b0,
        CMD_ABORT = 1'b1
    } cap_cmd_t;

endpackage

// File: sample_divider.sv
`timescale 1ns/10ps

`include "scope_params.svh"

// Timebase for the capture path
// One-cycle strobe every SCOPE_DIV clocks
module sample_divider (
    input  logic clk,
    input  logic rst,
    output logic sample_stb
);

    localparam int CNT_W = $clog2(`SCOPE_DIV);

    logic [CNT_W-1:0] cnt; // Clocks since last strobe

    // Terminal count gives the strobe
    assign sample_stb = (cnt == CNT_W'(`SCOPE_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (sample_stb) begin
            cnt <= '0; // Wrap on terminal count
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: level_trigger.sv
`timescale 1ns/10ps

`include "scope_params.svh"

// Hysteresis level trigger
// Signal must first leave the band on the far side, then reach the level
module level_trigger (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_stb,
    input  logic                       trig_armed,
    input  logic [`SCOPE_SAMPLE_W-1:0] adc_data,
    input  logic [`SCOPE_SAMPLE_W-1:0] trig_level,
    input  trigger_pkg::slope_t        slope,
    output logic                       trig_stb
);

    trigger_pkg::trig_state_t state;
    trigger_pkg::trig_state_t state_nxt;

    logic [`SCOPE_SAMPLE_W-1:0] level_q; // Level held for the whole arm period
    trigger_pkg::slope_t        slope_q;

    // One extra bit so level +/- hysteresis never wraps
    logic [`SCOPE_SAMPLE_W:0] adc_ext;
    logic [`SCOPE_SAMPLE_W:0] lvl_ext;

    logic below_band; // Under level - hyst
    logic above_band; // Over level + hyst
    logic far_side;   // Beyond the band on the re-arm side
    logic crossed;    // At or past level in the trigger direction

    ////////////////////////////////////////////////////////////////////////////
    // Comparators
    ////////////////////////////////////////////////////////////////////////////

    assign adc_ext = {1'b0, adc_data};
    assign lvl_ext = {1'b0, level_q};

    assign below_band = (adc_ext + (`SCOPE_SAMPLE_W+1)'(`SCOPE_HYST)) < lvl_ext;
    assign above_band = adc_ext > (lvl_ext + (`SCOPE_SAMPLE_W+1)'(`SCOPE_HYST));

    always_comb begin
        if (slope_q == trigger_pkg::SLOPE_RISE) begin
            far_side = below_band;           // Rising needs a low start
            crossed  = adc_data >= level_q;
        end else begin
            far_side = above_band;           // Falling needs a high start
            crossed  = adc_data <= level_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Trigger FSM
    ////////////////////////////////////////////////////////////////////////////

    // Fires in the same cycle as the crossing sample
    assign trig_stb = sample_stb && (state == trigger_pkg::TRIG_WAIT_CROSS) && crossed;

    always_comb begin
        state_nxt = state;
        case (state)
            trigger_pkg::TRIG_IDLE: begin
                if (trig_armed) state_nxt = trigger_pkg::TRIG_WAIT_FAR;
            end
            trigger_pkg::TRIG_WAIT_FAR: begin
                if (sample_stb && far_side) state_nxt = trigger_pkg::TRIG_WAIT_CROSS;
            end
            trigger_pkg::TRIG_WAIT_CROSS: begin
                if (trig_stb) state_nxt = trigger_pkg::TRIG_IDLE; // One shot per arm
            end
            default: state_nxt = trigger_pkg::TRIG_IDLE;
        endcase
        // Disarm drops back from anywhere
        if (!trig_armed) state_nxt = trigger_pkg::TRIG_IDLE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= trigger_pkg::TRIG_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Level and slope taken when arming starts
    always_ff @(posedge clk) begin
        if (state == trigger_pkg::TRIG_IDLE && trig_armed) begin
            level_q <= trig_level;
            slope_q <= slope;
        end
    end

endmodule

// File: capture_buffer.sv
`timescale 1ns/10ps

`include "scope_params.svh"

// Capture sequencing and sample memory
// Host arms, trigger starts the record, host reads words back
module capture_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_stb,
    input  capture_pkg::cap_cmd_t      cmd,
    input  logic                       sample_stb,
    input  logic                       trig_stb,
    input  logic [`SCOPE_SAMPLE_W-1:0] adc_data,
    input  logic                       rd_stb,
    input  logic [`SCOPE_ADDR_W-1:0]   rd_addr,
    output logic                       trig_armed,
    output capture_pkg::cap_status_t   status,
    output logic                       rd_valid,
    output logic [`SCOPE_SAMPLE_W-1:0] rd_data
);

    logic [`SCOPE_SAMPLE_W-1:0] mem [0:`SCOPE_DEPTH-1]; // Capture record

    logic [`SCOPE_ADDR_W-1:0] wr_ptr;  // Next address during a run
    logic [`SCOPE_ADDR_W-1:0] wr_addr;
    logic                     wr_en;
    logic                     do_arm;
    logic                     do_abort;
    logic                     last_word;

    ////////////////////////////////////////////////////////////////////////////
    // Command decode and write control
    ////////////////////////////////////////////////////////////////////////////

    assign do_abort = cmd_stb && (cmd == capture_pkg::CMD_ABORT);
    // Arm only honoured when no record is in progress
    assign do_arm   = cmd_stb && (cmd == capture_pkg::CMD_ARM) &&
                      (status == capture_pkg::CAP_IDLE || status == capture_pkg::CAP_DONE);

    assign trig_armed = (status == capture_pkg::CAP_ARMED);

    // First word on the trigger strobe, the rest on every strobe while running
    assign wr_en = sample_stb && !do_abort &&
                   ((trig_armed && trig_stb) || status == capture_pkg::CAP_RUN);
    assign wr_addr   = trig_armed ? '0 : wr_ptr;
    assign last_word = (wr_ptr == `SCOPE_ADDR_W'(`SCOPE_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= capture_pkg::CAP_IDLE;
            wr_ptr <= '0;
        end else if (do_abort) begin
            status <= capture_pkg::CAP_IDLE; // Abort wins over everything
        end else if (do_arm) begin
            status <= capture_pkg::CAP_ARMED;
        end else if (wr_en) begin
            wr_ptr <= wr_addr + 1'b1;
            if (trig_armed) begin
                status <= capture_pkg::CAP_RUN;
            end else if (last_word) begin
                status <= capture_pkg::CAP_DONE; // Record full, memory now frozen
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= adc_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readout port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_stb; // Data follows one cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) rd_data <= mem[rd_addr];
    end

endmodule

// File: scope_capture_top.sv
`timescale 1ns/10ps

`include "scope_params.svh"

// Single-channel scope capture
// Divider sets the timebase, trigger finds the edge, buffer stores the record
module scope_capture_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_stb,
    input  capture_pkg::cap_cmd_t      cmd,
    input  logic [`SCOPE_SAMPLE_W-1:0] trig_level,
    input  trigger_pkg::slope_t        slope,
    input  logic                       rd_stb,
    input  logic [`SCOPE_ADDR_W-1:0]   rd_addr,
    input  logic [`SCOPE_SAMPLE_W-1:0] adc_data,
    output logic                       sample_stb,
    output capture_pkg::cap_status_t   status,
    output logic                       rd_valid,
    output logic [`SCOPE_SAMPLE_W-1:0] rd_data
);

    logic trig_armed; // Buffer waiting for a trigger
    logic trig_stb;   // Crossing seen on this sample

    sample_divider divider_i (
        .clk        (clk),
        .rst        (rst),
        .sample_stb (sample_stb)
    );

    level_trigger trigger_i (
        .clk        (clk),
        .rst        (rst),
        .sample_stb (sample_stb),
        .trig_armed (trig_armed),
        .adc_data   (adc_data),
        .trig_level (trig_level),
        .slope      (slope),
        .trig_stb   (trig_stb)
    );

    capture_buffer buffer_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_stb    (cmd_stb),
        .cmd        (cmd),
        .sample_stb (sample_stb),
        .trig_stb   (trig_stb),
        .adc_data   (adc_data),
        .rd_stb     (rd_stb),
        .rd_addr    (rd_addr),
        .trig_armed (trig_armed),
        .status     (status),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

// Free-running testbench clock plus power-on reset
module tb_clk_gen #(
    parameter int HALF_PERIOD = 4, // 8 ns clock
    parameter int RST_CYCLES  = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0; // Released on a falling edge like every other input
    end

endmodule

// File: scope_capture_tb.sv
`timescale 1ns/10ps

`include "scope_params.svh"

// Scope capture testbench
// Script-driven with a cycle model of divider, trigger and capture checked every cycle
module scope_capture_tb;

    localparam string STIM_FILE   = "scope_stim.txt";
    localparam int    RST_TIMEOUT = 20;                // Cycles allowed for reset release
    localparam int    STB_TIMEOUT = 4 * `SCOPE_DIV;    // Cycles allowed per sample strobe

    logic                         clk;
    logic                         rst;
    logic                         cmd_stb;
    capture_pkg::cap_cmd_t        cmd;
    logic [`SCOPE_SAMPLE_W-1:0]   trig_level;
    trigger_pkg::slope_t          slope;
    logic                         rd_stb;
    logic [`SCOPE_ADDR_W-1:0]     rd_addr;
    logic [`SCOPE_SAMPLE_W-1:0]   adc_data;
    logic                         sample_stb;
    capture_pkg::cap_status_t     status;
    logic                         rd_valid;
    logic [`SCOPE_SAMPLE_W-1:0]   rd_data;

    // Reference model state
    capture_pkg::cap_status_t     exp_status;
    trigger_pkg::trig_state_t     m_trig;       // Modelled hysteresis state
    logic [`SCOPE_SAMPLE_W-1:0]   m_level;      // Level latched on arm
    trigger_pkg::slope_t          m_slope;
    logic [`SCOPE_SAMPLE_W-1:0]   exp_mem [0:`SCOPE_DEPTH-1];
    int                           m_ptr;        // Next record address
    logic                         exp_rd_valid;
    logic [`SCOPE_SAMPLE_W-1:0]   exp_rd_data;
    int                           stb_phase;    // Clock position within the timebase

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    scope_capture_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_stb    (cmd_stb),
        .cmd        (cmd),
        .trig_level (trig_level),
        .slope      (slope),
        .rd_stb     (rd_stb),
        .rd_addr    (rd_addr),
        .adc_data   (adc_data),
        .sample_stb (sample_stb),
        .status     (status),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_status(input string name, input capture_pkg::cap_status_t got,
                                input capture_pkg::cap_status_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [`SCOPE_SAMPLE_W-1:0] got,
                              input logic [`SCOPE_SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model called once per clock after the falling-edge drive
    ////////////////////////////////////////////////////////////////////////////

    // Sample beyond the band on the re-arm side
    function automatic logic beyond_band(input int a, input int l,
                                         input trigger_pkg::slope_t s);
        if (s == trigger_pkg::SLOPE_RISE) return a < l - `SCOPE_HYST;
        return a > l + `SCOPE_HYST;
    endfunction

    // Sample at or past the level in the trigger direction
    function automatic logic reached_level(input int a, input int l,
                                           input trigger_pkg::slope_t s);
        if (s == trigger_pkg::SLOPE_RISE) return a >= l;
        return a <= l;
    endfunction

    task automatic model_cycle();
        logic                     exp_stb;
        logic                     armed;
        logic                     fire;
        int                       a;
        int                       l;
        trigger_pkg::trig_state_t trig_nxt;
        exp_stb = (stb_phase == `SCOPE_DIV - 1);
        check_flag("sample_stb", sample_stb, exp_stb);
        check_status("status", status, exp_status);
        check_flag("rd_valid", rd_valid, exp_rd_valid);
        if (exp_rd_valid) check_word("rd_data", rd_data, exp_rd_data);
        // Read sees memory before this cycle's write
        exp_rd_valid = rd_stb;
        if (rd_stb) exp_rd_data = exp_mem[rd_addr];
        armed    = (exp_status == capture_pkg::CAP_ARMED);
        fire     = 1'b0;
        a        = int'(adc_data);
        l        = int'(m_level);
        trig_nxt = m_trig;
        case (m_trig)
            trigger_pkg::TRIG_IDLE: begin
                if (armed) begin
                    m_level  = trig_level; // Taken as arming starts
                    m_slope  = slope;
                    trig_nxt = trigger_pkg::TRIG_WAIT_FAR;
                end
            end
            trigger_pkg::TRIG_WAIT_FAR: begin
                if (exp_stb && beyond_band(a, l, m_slope)) begin
                    trig_nxt = trigger_pkg::TRIG_WAIT_CROSS;
                end
            end
            default: begin
                if (exp_stb && reached_level(a, l, m_slope)) begin
                    fire     = 1'b1;
                    trig_nxt = trigger_pkg::TRIG_IDLE;
                end
            end
        endcase
        if (!armed) trig_nxt = trigger_pkg::TRIG_IDLE;
        m_trig = trig_nxt;
        // Abort takes priority over arm and record writes
        if (cmd_stb && cmd == capture_pkg::CMD_ABORT) begin
            exp_status = capture_pkg::CAP_IDLE;
        end else if (cmd_stb && cmd == capture_pkg::CMD_ARM &&
                     (exp_status == capture_pkg::CAP_IDLE ||
                      exp_status == capture_pkg::CAP_DONE)) begin
            exp_status = capture_pkg::CAP_ARMED;
        end else if (exp_stb && armed && fire) begin
            exp_mem[0] = adc_data; // Crossing sample opens the record
            m_ptr      = 1;
            exp_status = capture_pkg::CAP_RUN;
        end else if (exp_stb && exp_status == capture_pkg::CAP_RUN) begin
            exp_mem[m_ptr] = adc_data;
            if (m_ptr == `SCOPE_DEPTH - 1) exp_status = capture_pkg::CAP_DONE;
            m_ptr = m_ptr + 1;
        end
        stb_phase = (stb_phase + 1) % `SCOPE_DIV;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host operations driven on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_cycle();
        @(negedge clk);
        cmd_stb = 1'b0; // Strobes last one cycle
        rd_stb  = 1'b0;
    endtask

    task automatic do_arm(input logic [`SCOPE_SAMPLE_W-1:0] level, input trigger_pkg::slope_t sl);
        begin_cycle();
        cmd_stb    = 1'b1;
        cmd        = capture_pkg::CMD_ARM;
        trig_level = level; // Held until the next arm
        slope      = sl;
        model_cycle();
    endtask

    task automatic do_abort();
        begin_cycle();
        cmd_stb = 1'b1;
        cmd     = capture_pkg::CMD_ABORT;
        model_cycle();
    endtask

    // One ADC word, held until a strobe takes it
    task automatic drive_sample(input logic [`SCOPE_SAMPLE_W-1:0] value);
        int waited;
        begin_cycle();
        adc_data = value;
        model_cycle();
        waited = 0;
        while (!sample_stb) begin
            begin_cycle();
            model_cycle();
            waited = waited + 1;
            if (waited > STB_TIMEOUT) begin
                $display("timed out waiting for sample_stb after driving a sample");
                stop_on_failure();
            end
        end
    endtask

    task automatic do_read(input logic [`SCOPE_ADDR_W-1:0] addr,
                           input logic [`SCOPE_SAMPLE_W-1:0] file_word);
        int gap;
        gap = int'($urandom % 3); // Random idle gap before the request
        repeat (gap) begin
            begin_cycle();
            model_cycle();
        end
        begin_cycle();
        rd_stb  = 1'b1;
        rd_addr = addr;
        check_word("expected rd_data", exp_mem[addr], file_word); // Script vs model
        model_cycle();  // rd_valid checked on the next call
    endtask

    task automatic check_status_line(input capture_pkg::cap_status_t file_status);
        begin_cycle();
        check_status("status", status, file_status);
        model_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus script
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_line(input logic [7:0] op, input string line);
        int                         n;
        int                         v1;
        int                         v2;
        int                         v3;
        int                         i;
        int                         smp;
        string                      tok;
        n = 0;
        case (op)
            "A": begin
                n = $sscanf(line, "%s %h %d", tok, v1, v2);
                if (n != 3) begin
                    $display("malformed arm line in stimulus file: %s", line);
                    stop_on_failure();
                end
                do_arm(v1[`SCOPE_SAMPLE_W-1:0], trigger_pkg::slope_t'(v2[0]));
            end
            "X": do_abort();
            "D": begin
                n = $sscanf(line, "%s %h", tok, v1);
                if (n != 2) begin
                    $display("malformed sample line in stimulus file: %s", line);
                    stop_on_failure();
                end
                drive_sample(v1[`SCOPE_SAMPLE_W-1:0]);
            end
            "P": begin
                n = $sscanf(line, "%s %h %d %d", tok, v1, v2, v3);
                if (n != 4) begin
                    $display("malformed ramp line in stimulus file: %s", line);
                    stop_on_failure();
                end
                for (i = 0; i < v3; i++) begin
                    smp = v1 + i * v2;
                    drive_sample(smp[`SCOPE_SAMPLE_W-1:0]);
                end
            end
            "R": begin
                n = $sscanf(line, "%s %d %h", tok, v1, v2);
                if (n != 3) begin
                    $display("malformed read line in stimulus file: %s", line);
                    stop_on_failure();
                end
                do_read(v1[`SCOPE_ADDR_W-1:0], v2[`SCOPE_SAMPLE_W-1:0]);
            end
            "S": begin
                n = $sscanf(line, "%s %d", tok, v1);
                if (n != 2) begin
                    $display("malformed status line in stimulus file: %s", line);
                    stop_on_failure();
                end
                check_status_line(capture_pkg::cap_status_t'(v1[1:0]));
            end
            default: begin
                $display("unknown operation in stimulus file: %s", line);
                stop_on_failure();
            end
        endcase
    endtask

    task automatic run_stim_file();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0) begin
                op = line.getc(0);
                if (op >= "A" && op <= "Z") run_line(op, line); // Comments and blanks skipped
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          waited;
        int unsigned seed_ret;
        cmd_stb      = 1'b0;
        cmd          = capture_pkg::CMD_ARM;
        trig_level   = '0;
        slope        = trigger_pkg::SLOPE_RISE;
        rd_stb       = 1'b0;
        rd_addr      = '0;
        adc_data     = '0;
        exp_status   = capture_pkg::CAP_IDLE;
        m_trig       = trigger_pkg::TRIG_IDLE;
        m_level      = '0;
        m_slope      = trigger_pkg::SLOPE_RISE;
        m_ptr        = 0;
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
        seed_ret     = $urandom(32'hbd073334);
        waited       = 0;
        do begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > RST_TIMEOUT) begin
                $display("timed out waiting for reset release");
                stop_on_failure();
            end
        end while (rst);
        stb_phase = 1; // Divider already one clock past reset here
        model_cycle();
        run_stim_file();
        repeat (4) begin
            begin_cycle(); // Lets the last read come back
            model_cycle();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: scope_capture_top.f
+incdir+.
trigger_pkg.sv
capture_pkg.sv
sample_divider.sv
level_trigger.sv
capture_buffer.sv
scope_capture_top.sv
tb_clk_gen.sv
scope_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the scope capture testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f scope_capture_top.f --top-module scope_capture_tb \
    -o scope_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/scope_sim > "$LOG" 2>&1 ; cat "$LOG"

grep -q "Result: FAILED" "$LOG" && exit 1
grep -q "Result: PASSED" "$LOG" || { echo "no verdict in $LOG"; exit 1; }
exit 0

// File: scope_stim.txt
# op: A level(hex) slope(0 rise, 1 fall) | X abort | D sample(hex)
# op: P start(hex) step(dec) count(dec) | R addr(dec) word(hex) | S status(0 idle .. 3 done)
S 0
# Rising trigger at 0x800, band edge 0x7f8
A 800 0
S 1
D 810
D 7fc
S 1
D 7f0
D 7fa
S 1
P 7fe 3 40
S 3
R 0 801
R 1 804
R 15 82e
R 30 85b
R 31 85e
# Falling trigger at 0x400, re-armed from done, band edge 0x408
A 400 1
S 1
P 3f0 2 12
S 1
R 0 801
D 40a
P 406 -3 34
S 3
R 0 400
R 1 3fd
R 16 3d0
R 31 3a3
# Abort while armed, later crossing must not capture
A 200 0
S 1
D 100
X
S 0
P 1f0 8 4
S 0
R 0 400
# Fresh record after abort
A 200 0
S 1
D 100
P 1fc 4 33
S 3
R 0 200
R 5 214
R 31 27c
